//--- rtl/logic_consts.svh
// Width is fixed at 32 bits; bit reverse and byte lane operations depend on it
`ifndef LOGIC_CONSTS_SVH
`define LOGIC_CONSTS_SVH

// Data path
`define LOGIC_WIDTH 32

// Instruction word fields, from the top bit down
`define LOGIC_CMD_W 5
`define LOGIC_REG_W 4
`define LOGIC_IMM_W 16
`define LOGIC_PAD_W 6
`define LOGIC_RSVD_W 22

// Command code limits
`define LOGIC_CMD_HOLE 5'h13
`define LOGIC_CMD_LAST 5'h16

`endif

//--- rtl/logic_pkg.sv
// Command codes 0x13 and above 0x16 are not enumerated and decode as illegal
`include "logic_consts.svh"

package logic_pkg;

	typedef enum logic [`LOGIC_CMD_W-1:0] {
		CMD_BUF_A    = 5'h00,
		CMD_BUF_B    = 5'h01,
		CMD_INV_A    = 5'h02,
		CMD_INV_B    = 5'h03,
		CMD_AND      = 5'h04,
		CMD_OR       = 5'h05,
		CMD_XOR      = 5'h06,
		CMD_NAND     = 5'h07,
		CMD_NOR      = 5'h08,
		CMD_XNOR     = 5'h09,
		CMD_SET_BIT  = 5'h0A,
		CMD_CLR_BIT  = 5'h0B,
		CMD_BIT_REV  = 5'h0C,
		CMD_BYTE_REV = 5'h0D,
		CMD_GET_BIT  = 5'h0E,
		CMD_GET_BYTE = 5'h0F,
		CMD_SET_LOW  = 5'h10,
		CMD_SET_HIGH = 5'h11,
		CMD_LI_S     = 5'h12,	// Sign-extended immediate load
		CMD_LI_U     = 5'h14,	// Zero-extended immediate load
		CMD_CLR_WORD = 5'h15,
		CMD_SET_WORD = 5'h16
	} logic_cmd_e;

	// Register form, low bits unused
	typedef struct packed {
		logic_cmd_e cmd;
		logic imm_sel;
		logic [`LOGIC_REG_W-1:0] dest;
		logic [`LOGIC_RSVD_W-1:0] rsvd;
	} instr_reg_t;

	// Immediate form, imm replaces the second operand
	typedef struct packed {
		logic_cmd_e cmd;
		logic imm_sel;
		logic [`LOGIC_REG_W-1:0] dest;
		logic [`LOGIC_PAD_W-1:0] pad;
		logic [`LOGIC_IMM_W-1:0] imm;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_word_u;

endpackage

//--- rtl/logic_decode.sv
// Operands are sampled only on instr_valid; the immediate form zero-extends the 16-bit field
`timescale 1ns/1ps
`include "logic_consts.svh"

module logic_decode
	import logic_pkg::*;
(
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      instr_valid,
	input  instr_word_u               instr,
	input  logic [`LOGIC_WIDTH-1:0]   src_a,
	input  logic [`LOGIC_WIDTH-1:0]   src_b,
	output logic                      dec_valid,
	output logic_cmd_e                dec_cmd,
	output logic [`LOGIC_WIDTH-1:0]   dec_data0,
	output logic [`LOGIC_WIDTH-1:0]   dec_data1,
	output logic [`LOGIC_REG_W-1:0]   dec_dest,
	output logic                      dec_illegal
);

	logic [`LOGIC_WIDTH-1:0] imm_ext;
	logic [`LOGIC_WIDTH-1:0] operand_b;
	logic                    cmd_illegal;

	// Both views share the command field, the register view is used here
	assign imm_ext = {{(`LOGIC_WIDTH - `LOGIC_IMM_W){1'b0}}, instr.i.imm};
	assign operand_b = instr.r.imm_sel ? imm_ext : src_b;	// Immediate replaces src_b

	// One hole in the code space plus everything past the last command
	assign cmd_illegal = (instr.r.cmd == `LOGIC_CMD_HOLE) ||
		(instr.r.cmd > `LOGIC_CMD_LAST);

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			dec_valid   <= 1'b0;
			dec_cmd     <= CMD_BUF_A;
			dec_data0   <= '0;
			dec_data1   <= '0;
			dec_dest    <= '0;
			dec_illegal <= 1'b0;
		end
		else
		begin
			dec_valid <= instr_valid;	// One cycle strobe
			if (instr_valid)
			begin
				dec_cmd     <= instr.r.cmd;
				dec_data0   <= src_a;
				dec_data1   <= operand_b;
				dec_dest    <= instr.r.dest;
				dec_illegal <= cmd_illegal;
			end
		end
	end

endmodule

//--- rtl/logic_n.sv
// Purely combinational; unknown command codes pass data0 through unchanged
`timescale 1ns/1ps
`include "logic_consts.svh"

module logic_n
	import logic_pkg::*;
(
	input  logic_cmd_e                cmd,
	input  logic [`LOGIC_WIDTH-1:0]   data0,
	input  logic [`LOGIC_WIDTH-1:0]   data1,
	output logic [`LOGIC_WIDTH-1:0]   data,
	output logic                      sf,
	output logic                      pf,
	output logic                      zf
);

	logic [4:0]              bit_idx;
	logic [`LOGIC_WIDTH-1:0] bit_mask;
	logic [`LOGIC_WIDTH-1:0] bit_rev;
	logic [7:0]              byte_sel;

	assign bit_idx  = data1[4:0];	// Bit index from low 5 bits only
	assign bit_mask = {{(`LOGIC_WIDTH-1){1'b0}}, 1'b1} << bit_idx;

	always_comb
	begin
		for (int i = 0; i < `LOGIC_WIDTH; i++)
		begin
			bit_rev[i] = data0[`LOGIC_WIDTH-1-i];
		end
	end

	// Byte lane picked by data1[1:0], lane 0 is the low byte
	always_comb
	begin
		case (data1[1:0])
			2'h0: byte_sel = data0[7:0];
			2'h1: byte_sel = data0[15:8];
			2'h2: byte_sel = data0[23:16];
			default: byte_sel = data0[31:24];
		endcase
	end

	always_comb
	begin
		case (cmd)
			CMD_BUF_A:    data = data0;
			CMD_BUF_B:    data = data1;
			CMD_INV_A:    data = ~data0;
			CMD_INV_B:    data = ~data1;
			CMD_AND:      data = data0 & data1;
			CMD_OR:       data = data0 | data1;
			CMD_XOR:      data = data0 ^ data1;
			CMD_NAND:     data = ~(data0 & data1);
			CMD_NOR:      data = ~(data0 | data1);
			CMD_XNOR:     data = ~(data0 ^ data1);
			CMD_SET_BIT:  data = data0 | bit_mask;
			CMD_CLR_BIT:  data = data0 & ~bit_mask;
			CMD_BIT_REV:  data = bit_rev;
			CMD_BYTE_REV: data = {data0[7:0], data0[15:8], data0[23:16], data0[31:24]};
			CMD_GET_BIT:  data = {{(`LOGIC_WIDTH-1){1'b0}}, data0[bit_idx]};
			CMD_GET_BYTE: data = {{(`LOGIC_WIDTH-8){1'b0}}, byte_sel};
			CMD_SET_LOW:  data = {data0[31:16], data1[15:0]};	// Keep upper half of a
			CMD_SET_HIGH: data = {data1[15:0], data0[15:0]};	// Keep lower half of a
			CMD_LI_S:     data = {{16{data1[15]}}, data1[15:0]};
			CMD_LI_U:     data = {16'h0000, data1[15:0]};
			CMD_CLR_WORD: data = '0;
			CMD_SET_WORD: data = '1;
			default:      data = data0;	// Illegal code, pass a through
		endcase
	end

	// Flags follow the result word
	assign sf = data[`LOGIC_WIDTH-1];
	assign pf = data[0];	// Low bit only, not a full parity
	assign zf = (data == '0);

endmodule

//--- rtl/logic_result.sv
// Retained flags update only on valid legal results; result_illegal is a strobe with result_valid
`timescale 1ns/1ps
`include "logic_consts.svh"

module logic_result
(
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      dec_valid,
	input  logic [`LOGIC_REG_W-1:0]   dec_dest,
	input  logic                      dec_illegal,
	input  logic [`LOGIC_WIDTH-1:0]   exe_data,
	input  logic                      exe_sf,
	input  logic                      exe_pf,
	input  logic                      exe_zf,
	output logic                      result_valid,
	output logic [`LOGIC_WIDTH-1:0]   result_data,
	output logic [`LOGIC_REG_W-1:0]   result_dest,
	output logic                      result_illegal,
	output logic                      sf,
	output logic                      pf,
	output logic                      zf,
	output logic                      flag_sf,
	output logic                      flag_pf,
	output logic                      flag_zf
);

	logic flag_load;

	assign flag_load = dec_valid && !dec_illegal;

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			result_valid   <= 1'b0;
			result_illegal <= 1'b0;
			result_data    <= '0;
			result_dest    <= '0;
			sf             <= 1'b0;
			pf             <= 1'b0;
			zf             <= 1'b0;
			flag_sf        <= 1'b0;
			flag_pf        <= 1'b0;
			flag_zf        <= 1'b0;
		end
		else
		begin
			result_valid   <= dec_valid;
			result_illegal <= dec_valid && dec_illegal;	// Low between results
			if (dec_valid)
			begin
				result_data <= exe_data;	// Illegal codes still write data0
				result_dest <= dec_dest;
				sf          <= exe_sf;
				pf          <= exe_pf;
				zf          <= exe_zf;
			end
			if (flag_load)
			begin
				flag_sf <= exe_sf;
				flag_pf <= exe_pf;
				flag_zf <= exe_zf;
			end
		end
	end

endmodule

//--- rtl/logic_core.sv
// Two-cycle latency from instr_valid to result_valid, no back-pressure, one instruction per cycle
`timescale 1ns/1ps
`include "logic_consts.svh"

module logic_core
	import logic_pkg::*;
(
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      instr_valid,
	input  logic [`LOGIC_WIDTH-1:0]   instr,
	input  logic [`LOGIC_WIDTH-1:0]   src_a,
	input  logic [`LOGIC_WIDTH-1:0]   src_b,
	output logic                      result_valid,
	output logic [`LOGIC_WIDTH-1:0]   result_data,
	output logic [`LOGIC_REG_W-1:0]   result_dest,
	output logic                      result_illegal,
	output logic                      sf,
	output logic                      pf,
	output logic                      zf,
	output logic                      flag_sf,
	output logic                      flag_pf,
	output logic                      flag_zf
);

	logic                    dec_valid;
	logic_cmd_e              dec_cmd;
	logic [`LOGIC_WIDTH-1:0] dec_data0;
	logic [`LOGIC_WIDTH-1:0] dec_data1;
	logic [`LOGIC_REG_W-1:0] dec_dest;
	logic                    dec_illegal;
	logic [`LOGIC_WIDTH-1:0] exe_data;
	logic                    exe_sf;
	logic                    exe_pf;
	logic                    exe_zf;

	logic_decode u_decode (
		.clock       (clock),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),	// Raw word viewed through the union
		.src_a       (src_a),
		.src_b       (src_b),
		.dec_valid   (dec_valid),
		.dec_cmd     (dec_cmd),
		.dec_data0   (dec_data0),
		.dec_data1   (dec_data1),
		.dec_dest    (dec_dest),
		.dec_illegal (dec_illegal)
	);

	logic_n u_execute (
		.cmd   (dec_cmd),
		.data0 (dec_data0),
		.data1 (dec_data1),
		.data  (exe_data),
		.sf    (exe_sf),
		.pf    (exe_pf),
		.zf    (exe_zf)
	);

	logic_result u_result (
		.clock          (clock),
		.rst_n          (rst_n),
		.dec_valid      (dec_valid),
		.dec_dest       (dec_dest),
		.dec_illegal    (dec_illegal),
		.exe_data       (exe_data),
		.exe_sf         (exe_sf),
		.exe_pf         (exe_pf),
		.exe_zf         (exe_zf),
		.result_valid   (result_valid),
		.result_data    (result_data),
		.result_dest    (result_dest),
		.result_illegal (result_illegal),
		.sf             (sf),
		.pf             (pf),
		.zf             (zf),
		.flag_sf        (flag_sf),
		.flag_pf        (flag_pf),
		.flag_zf        (flag_zf)
	);

endmodule

//--- testbench/tb_clock_gen.sv
// Free-running clock with a 20 ns period, starting low at time zero
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clock
);

	initial
	begin
		clock = 1'b0;
	end

	always #10 clock = ~clock;	// Half period

endmodule

//--- testbench/logic_checker.sv
// Inputs are taken at the rising edge and outputs compared at the falling edge, two stages apart
`timescale 1ns/1ps
`include "logic_consts.svh"

module logic_checker
	import logic_pkg::*;
(
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    instr_valid,
	input  logic [`LOGIC_WIDTH-1:0] instr,
	input  logic [`LOGIC_WIDTH-1:0] src_a,
	input  logic [`LOGIC_WIDTH-1:0] src_b,
	input  logic                    result_valid,
	input  logic [`LOGIC_WIDTH-1:0] result_data,
	input  logic [`LOGIC_REG_W-1:0] result_dest,
	input  logic                    result_illegal,
	input  logic                    sf,
	input  logic                    pf,
	input  logic                    zf,
	input  logic                    flag_sf,
	input  logic                    flag_pf,
	input  logic                    flag_zf,
	output int                      check_count,
	output int                      error_count
);

	logic        exp_valid [0:1];
	logic        exp_illegal [0:1];
	logic [31:0] exp_data [0:1];
	logic [3:0]  exp_dest [0:1];
	logic        mdl_sf = 1'b0;	// Retained flag model
	logic        mdl_pf = 1'b0;
	logic        mdl_zf = 1'b0;

	// Expected result built from the command list
	function automatic logic [31:0] ref_result(input logic [4:0] code, input logic [31:0] a,
		input logic [31:0] b);
		logic [31:0] r;
		r = a;	// Illegal codes return data0
		case (code)
			5'h00: r = a;
			5'h01: r = b;
			5'h02: r = ~a;
			5'h03: r = ~b;
			5'h04: r = a & b;
			5'h05: r = a | b;
			5'h06: r = a ^ b;
			5'h07: r = ~(a & b);
			5'h08: r = ~(a | b);
			5'h09: r = ~(a ^ b);
			5'h0A: r = a | (32'h1 << b[4:0]);
			5'h0B: r = a & ~(32'h1 << b[4:0]);
			5'h0C: for (int i = 0; i < 32; i++) r[i] = a[31-i];
			5'h0D: for (int k = 0; k < 4; k++) r[8*k +: 8] = a[8*(3-k) +: 8];
			5'h0E: r = (a >> b[4:0]) & 32'h1;
			5'h0F: r = (a >> {b[1:0], 3'b000}) & 32'hFF;
			5'h10: r = (a & 32'hFFFF_0000) | (b & 32'h0000_FFFF);
			5'h11: r = (a & 32'h0000_FFFF) | (b << 16);
			5'h12: r = {{16{b[15]}}, b[15:0]};
			5'h14: r = b & 32'h0000_FFFF;
			5'h15: r = 32'h0;
			5'h16: r = 32'hFFFF_FFFF;
			default: r = a;
		endcase
		return r;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("FAIL at %0t: %s expected %h, actual %h", $time, name, expected, actual);
		end
	endtask

	initial
	begin
		check_count = 0;
		error_count = 0;
	end

	always @(posedge clock)
	begin
		instr_word_u word;
		logic [31:0] b_eff;
		word = instr;
		b_eff = word.i.imm_sel ? {16'h0000, word.i.imm} : src_b;
		exp_valid[1] = exp_valid[0];
		exp_illegal[1] = exp_illegal[0];
		exp_data[1] = exp_data[0];
		exp_dest[1] = exp_dest[0];
		exp_valid[0] = rst_n && instr_valid;
		exp_illegal[0] = (word.i.cmd == 5'h13) || (word.i.cmd > 5'h16);
		exp_data[0] = ref_result(word.i.cmd, src_a, b_eff);
		exp_dest[0] = word.i.dest;
		if (!rst_n)
			exp_valid[1] = 1'b0;
	end

	always @(negedge clock)
	begin
		if (!rst_n)
		begin
			mdl_sf = 1'b0;
			mdl_pf = 1'b0;
			mdl_zf = 1'b0;
		end
		else
		begin
			if (exp_valid[1] && !exp_illegal[1])
			begin
				mdl_sf = exp_data[1][31];
				mdl_pf = exp_data[1][0];
				mdl_zf = (exp_data[1] == 32'h0);
			end
			check_count++;
			if (result_valid !== exp_valid[1])
			begin
				error_count++;
				if (exp_valid[1])
					$display("Missing result_valid two cycles after an instruction at %0t", $time);
				else
					$display("Unexpected result_valid with no instruction at %0t", $time);
			end
			else if (exp_valid[1])
			begin
				compare("result_data", exp_data[1], result_data);
				compare("result_dest", 32'(exp_dest[1]), 32'(result_dest));
				compare("result_illegal", 32'(exp_illegal[1]), 32'(result_illegal));
				compare("sf", 32'(exp_data[1][31]), 32'(sf));
				compare("pf", 32'(exp_data[1][0]), 32'(pf));
				compare("zf", 32'(exp_data[1] == 32'h0), 32'(zf));
			end
			else
				compare("result_illegal", 32'h0, 32'(result_illegal));
			compare("flag_sf", 32'(mdl_sf), 32'(flag_sf));
			compare("flag_pf", 32'(mdl_pf), 32'(flag_pf));
			compare("flag_zf", 32'(mdl_zf), 32'(flag_zf));
		end
	end

endmodule

//--- testbench/logic_core_tb.sv
// Inputs change on the falling edge only; the run length is bounded by N_DIRECTED and N_RANDOM
`timescale 1ns/1ps
`include "logic_consts.svh"

module logic_core_tb
	import logic_pkg::*;
();

	localparam int N_DIRECTED = 80;	// Upper bound on directed issue slots
	localparam int N_RANDOM = 160;
	localparam int WATCHDOG_NS = (N_DIRECTED + N_RANDOM + 20) * 20;
	localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;
	localparam logic [31:0] OPA = 32'hF0F0_A5C3;
	localparam logic [31:0] OPB = 32'h3C3C_0F12;	// Bit index 18 in the low 5 bits

	logic clock;
	logic rst_n;
	logic instr_valid;
	instr_word_u instr;
	logic [`LOGIC_WIDTH-1:0] src_a;
	logic [`LOGIC_WIDTH-1:0] src_b;
	logic result_valid;
	logic [`LOGIC_WIDTH-1:0] result_data;
	logic [`LOGIC_REG_W-1:0] result_dest;
	logic result_illegal;
	logic sf;
	logic pf;
	logic zf;
	logic flag_sf;
	logic flag_pf;
	logic flag_zf;
	int check_count;
	int error_count;
	logic [31:0] lfsr_state = 32'd32;

	tb_clock_gen clock_gen (.clock(clock));

	logic_core UUT (
		.clock(clock), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
		.src_a(src_a), .src_b(src_b), .result_valid(result_valid),
		.result_data(result_data), .result_dest(result_dest),
		.result_illegal(result_illegal), .sf(sf), .pf(pf), .zf(zf),
		.flag_sf(flag_sf), .flag_pf(flag_pf), .flag_zf(flag_zf)
	);

	logic_checker result_checker (
		.clock(clock), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
		.src_a(src_a), .src_b(src_b), .result_valid(result_valid),
		.result_data(result_data), .result_dest(result_dest),
		.result_illegal(result_illegal), .sf(sf), .pf(pf), .zf(zf),
		.flag_sf(flag_sf), .flag_pf(flag_pf), .flag_zf(flag_zf),
		.check_count(check_count), .error_count(error_count)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic issue(input logic [4:0] code, input logic imm_sel, input logic [3:0] dest,
		input logic [15:0] imm, input logic [31:0] a, input logic [31:0] b);
		instr_word_u word;
		word = '0;
		word.i.cmd = logic_cmd_e'(code);
		word.i.imm_sel = imm_sel;
		word.i.dest = dest;
		word.i.pad = 6'h15;	// Ignored by decode
		word.i.imm = imm;	// Still present in register form, must be ignored
		@(negedge clock);
		instr_valid = 1'b1;
		instr = word;
		src_a = a;
		src_b = b;
	endtask

	task automatic idle_slot();
		@(negedge clock);
		instr_valid = 1'b0;
	endtask

	initial
	begin
		logic [31:0] r;
		logic [31:0] code_r;
		logic [31:0] ctl_r;
		logic [31:0] imm_r;
		logic [31:0] a_r;
		logic [4:0] idx;
		instr_valid = 1'b0;
		instr = '0;
		src_a = '0;
		src_b = '0;
		rst_n = 1'b0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		rst_n <= 1'b1;
		idle_slot();
		// All legal codes, register then immediate form
		for (int c = 0; c <= 22; c++)
		begin
			if (c != 19)
			begin
				issue(5'(c), 1'b0, 4'(c), 16'h8E71, OPA, OPB);
				issue(5'(c), 1'b1, 4'(c), 16'h8E71, OPA, OPB);
			end
		end
		// Set, clear and get bit at 0, 31 and two random indices
		for (int k = 0; k < 4; k++)
		begin
			draw_bits(5, r);
			idx = (k == 0) ? 5'd0 : (k == 1) ? 5'd31 : r[4:0];
			draw_bits(27, r);
			issue(5'h0A, 1'b0, 4'(k), 16'h0, 32'h5A5A_5A5A, {r[26:0], idx});
			issue(5'h0B, 1'b0, 4'(k), 16'h0, 32'h5A5A_5A5A, {r[26:0], idx});
			issue(5'h0E, 1'b0, 4'(k), 16'h0, 32'h5A5A_5A5A, {r[26:0], idx});
		end
		issue(5'h0C, 1'b0, 4'h1, 16'h0, 32'h1234_5678, OPB);
		issue(5'h0D, 1'b0, 4'h2, 16'h0, 32'h1234_5678, OPB);
		for (int lane = 0; lane < 4; lane++)
			issue(5'h0F, 1'b0, 4'(lane), 16'h0, 32'hDEAD_BEEF, {30'h0, 2'(lane)});
		idle_slot();
		// Flag corners
		issue(5'h15, 1'b0, 4'h3, 16'h0, OPA, OPB);
		issue(5'h16, 1'b0, 4'h4, 16'h0, OPA, OPB);
		issue(5'h00, 1'b0, 4'h5, 16'h0, 32'h8000_0001, OPB);
		issue(5'h00, 1'b0, 4'h6, 16'h0, 32'h7FFF_FFFE, OPB);
		// Illegal codes after set word, retained flags must hold
		issue(5'h16, 1'b0, 4'h7, 16'h0, OPA, OPB);
		issue(5'h13, 1'b0, 4'h8, 16'h0, 32'h0, OPB);
		issue(5'h17, 1'b1, 4'h9, 16'hFFFF, 32'h0, OPB);
		issue(5'h1F, 1'b0, 4'hA, 16'h0, 32'h8000_0001, OPB);
		idle_slot();
		// Random traffic, about one slot in four idle
		for (int n = 0; n < N_RANDOM; n++)
		begin
			draw_bits(2, r);
			if (r[1:0] == 2'b00)
				idle_slot();
			else
			begin
				draw_bits(5, code_r);
				draw_bits(5, ctl_r);
				draw_bits(16, imm_r);
				draw_bits(32, a_r);
				draw_bits(32, r);
				issue(code_r[4:0], ctl_r[4], ctl_r[3:0], imm_r[15:0], a_r, r);
			end
		end
		idle_slot();
		repeat (3) @(posedge clock);	// Two-cycle latency plus margin
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0 && check_count > 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- logic_core.f
+incdir+rtl
rtl/logic_pkg.sv
rtl/logic_decode.sv
rtl/logic_n.sv
rtl/logic_result.sv
rtl/logic_core.sv
testbench/tb_clock_gen.sv
testbench/logic_checker.sv
testbench/logic_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the logic_core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f logic_core.f --top-module logic_core_tb -o sim_logic_core
./obj_dir/sim_logic_core > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation completed successfully" sim.log; then
	exit 0
else
	echo "Run failed, see sim.log"
	exit 1
fi
